/* testbench/soc_patterns.txt */
// op_addr_value_expected in hex; op 1 write, 2 read, 3 buttons, 4 transmit, 5 receive,
// 6 led_o, 7 random RAM fill, 8 RAM readback; for 4 and 5 the addr field holds the byte
1_1008_00000008_00000000
2_1008_00000000_00000008
2_1014_00000000_00000000
7_0000_00000010_00000000
8_0000_00000010_00000000
2_0040_00000000_00000000
2_1018_00000000_00000000
2_8000_00000000_00000000
1_0040_deadbeef_00000000
1_1018_0badf00d_00000000
1_8000_ffffffff_00000000
8_0000_00000010_00000000
2_0040_00000000_00000000
2_1000_00000000_00000000
2_1008_00000000_00000008
1_1000_0000000a_00000000
6_0000_00000000_0000000a
2_1000_00000000_0000000a
3_0000_00000005_00000000
2_1004_00000000_00000005
3_0000_0000000c_00000000
2_1004_00000000_0000000c
4_00a5_0000003c_000000a5
4_0081_0000007e_00000081
5_0096_00000000_00000000
2_1014_00000000_00000002
2_1010_00000000_00000096
2_1014_00000000_00000000
5_0021_00000000_00000000
5_0042_00000000_00000000
2_1014_00000000_00000006
2_1010_00000000_00000021
2_1014_00000000_00000000

/* list.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/soc_ram.sv
rtl/soc_uart.sv
rtl/soc_ctrl_regs.sv
rtl/soc_bus_decoder.sv
rtl/soc_top.sv
testbench/soc_asserts.sv
testbench/tb_soc.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc -f list.f -o sim_soc

out=$(./obj_dir/sim_soc 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
  exit 0
fi
echo "run.sh: simulation did not pass" >&2
exit 1

/* testbench/tb_soc.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_soc
  import soc_pkg::*;
  ();

  localparam int       MAX_RECORDS = 64;
  localparam wb_addr_t BAUD_ADDR   = `SOC_REG_BASE + 16'h08;
  localparam wb_addr_t TXDATA_ADDR = `SOC_REG_BASE + 16'h0C;
  localparam wb_addr_t STATUS_ADDR = `SOC_REG_BASE + 16'h14;

  // record opcodes
  localparam logic [3:0] OP_WRITE    = 4'h1;
  localparam logic [3:0] OP_READ     = 4'h2;
  localparam logic [3:0] OP_BUTTONS  = 4'h3;
  localparam logic [3:0] OP_TRANSMIT = 4'h4;
  localparam logic [3:0] OP_RECEIVE  = 4'h5;
  localparam logic [3:0] OP_LED      = 4'h6;
  localparam logic [3:0] OP_FILL     = 4'h7;
  localparam logic [3:0] OP_VERIFY   = 4'h8;

  logic     clk_i;
  logic     anrst_i;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  wb_addr_t wb_adr_i;
  wb_data_t wb_dat_i;
  wb_data_t wb_dat_o;
  logic     wb_ack_o;
  logic     uart_rx_i;
  logic     uart_tx_o;
  led_t     btn_i;
  led_t     led_o;

  // op, addr, value, expected
  logic [83:0] patterns [0:MAX_RECORDS-1];
  wb_data_t    ram_model [0:(2**`SOC_RAM_ADDR_W)-1];
  int          num_records;
  int          bit_cycles;
  int          error_count;
  int          watchdog_cycles = 0;

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  soc_top u_dut (
    .clk_i     (clk_i),
    .anrst_i   (anrst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o),
    .btn_i     (btn_i),
    .led_o     (led_o)
  );

  //////////////////////
  // checks
  //////////////////////

  task automatic stop_with_failure(input string reason);
    error_count++;
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input wb_data_t expected, input wb_data_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error at %0t: %s expected %h, got %h",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic check_byte(input string name, input uart_byte_t expected,
                            input uart_byte_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error at %0t: %s expected %h, got %h",
                                  $time, name, expected, actual));
    end
  endtask

  task automatic check_led(input string name, input led_t expected, input led_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error at %0t: %s expected %h, got %h",
                                  $time, name, expected, actual));
    end
  endtask

  //////////////////////
  // bus and serial line
  //////////////////////

  // starts and ends on a falling edge
  task automatic bus_access(input logic write, input wb_addr_t addr, input wb_data_t wdata,
                            output wb_data_t rdata);
    int cycles;
    cycles = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = write;
    wb_adr_i = addr;
    wb_dat_i = wdata;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!wb_ack_o && cycles < 2);
    if (!wb_ack_o) begin
      stop_with_failure($sformatf("no acknowledge from address %h within 2 cycles", addr));
    end
    if (cycles != 1) begin
      stop_with_failure($sformatf("access to %h took %0d cycles instead of 2", addr, cycles + 1));
    end
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic fill_ram(input wb_addr_t base, input int count);
    wb_data_t value;
    wb_data_t ignored;
    wb_addr_t addr;
    for (int i = 0; i < count; i++) begin
      value = $urandom();
      addr  = base + wb_addr_t'(4 * i);
      ram_model[addr[`SOC_RAM_ADDR_W+1:2]] = value;
      bus_access(1'b1, addr, value, ignored);
    end
  endtask

  task automatic verify_ram(input wb_addr_t base, input int count);
    wb_data_t value;
    wb_addr_t addr;
    for (int i = 0; i < count; i++) begin
      addr = base + wb_addr_t'(4 * i);
      bus_access(1'b0, addr, '0, value);
      check_word($sformatf("wb_dat_o at %h", addr), ram_model[addr[`SOC_RAM_ADDR_W+1:2]], value);
    end
  endtask

  // samples each bit at its centre
  task automatic capture_frame(output uart_byte_t data);
    int waited;
    waited = 0;
    while (uart_tx_o && waited < 4 * bit_cycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (uart_tx_o) begin
      stop_with_failure("no start bit on uart_tx_o after the TXDATA write");
    end
    repeat (bit_cycles / 2) @(negedge clk_i);
    if (uart_tx_o) begin
      stop_with_failure("start bit on uart_tx_o ended before its centre");
    end
    for (int i = 0; i < 8; i++) begin
      repeat (bit_cycles) @(negedge clk_i);
      data[i] = uart_tx_o;
    end
    repeat (bit_cycles) @(negedge clk_i);
    if (!uart_tx_o) begin
      stop_with_failure("stop bit on uart_tx_o is low");
    end
  endtask

  task automatic transmit_byte(input uart_byte_t first, input uart_byte_t second,
                               input uart_byte_t expected);
    uart_byte_t frame;
    wb_data_t   status;
    wb_data_t   ignored;
    bus_access(1'b1, TXDATA_ADDR, wb_data_t'(first), ignored);
    fork
      capture_frame(frame);
      begin
        bus_access(1'b0, STATUS_ADDR, '0, status);
        check_word("STATUS.tx_busy", 32'd1, status & 32'd1);
        // this write lands while busy and must not start a frame
        bus_access(1'b1, TXDATA_ADDR, wb_data_t'(second), ignored);
      end
    join
    check_byte("uart_tx_o frame", expected, frame);
    repeat (2 * bit_cycles) begin
      @(negedge clk_i);
      if (!uart_tx_o) begin
        stop_with_failure("a second frame started on uart_tx_o");
      end
    end
    bus_access(1'b0, STATUS_ADDR, '0, status);
    check_word("STATUS.tx_busy", 32'd0, status & 32'd1);
  endtask

  task automatic send_frame(input uart_byte_t data);
    uart_rx_i = 1'b0;
    repeat (bit_cycles) @(negedge clk_i);
    for (int i = 0; i < 8; i++) begin
      uart_rx_i = data[i];
      repeat (bit_cycles) @(negedge clk_i);
    end
    uart_rx_i = 1'b1;
    // room for the synchronizer past the stop bit centre
    repeat (bit_cycles + 4) @(negedge clk_i);
  endtask

  task automatic load_patterns();
    int max_div;
    for (int i = 0; i < MAX_RECORDS; i++) begin
      patterns[i] = '0;
    end
    $readmemh("testbench/soc_patterns.txt", patterns);
    num_records = 0;
    max_div     = 1;
    while (num_records < MAX_RECORDS && patterns[num_records][83:80] != 4'h0) begin
      if (patterns[num_records][83:80] == OP_WRITE &&
          patterns[num_records][79:64] == BAUD_ADDR &&
          int'(patterns[num_records][47:32]) > max_div) begin
        max_div = int'(patterns[num_records][47:32]);
      end
      num_records++;
    end
    if (num_records == 0) begin
      stop_with_failure("pattern file testbench/soc_patterns.txt is empty or missing");
    end
    // reset and prologue get a fixed allowance
    watchdog_cycles = num_records * (12 * max_div + 20) + 64;
  endtask

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    stop_with_failure($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
  end

  //////////////////////
  // main sequence
  //////////////////////

  initial begin
    logic [83:0] rec;
    logic [3:0]  op;
    wb_addr_t    addr;
    wb_data_t    value;
    wb_data_t    expected;
    wb_data_t    rdata;

    error_count = 0;
    void'($urandom(32'haf48fb06));
    anrst_i    = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    uart_rx_i  = 1'b1;
    btn_i      = '0;
    bit_cycles = int'(`SOC_BAUD_RESET);
    load_patterns();

    repeat (8) @(negedge clk_i);
    anrst_i = 1'b1;
    repeat (4) @(negedge clk_i);

    // state out of reset
    check_led("led_o", '0, led_o);
    if (!uart_tx_o) begin
      stop_with_failure("uart_tx_o is not idle high after reset");
    end
    if (wb_ack_o) begin
      stop_with_failure("wb_ack_o is high after reset");
    end
    bus_access(1'b0, BAUD_ADDR, '0, rdata);
    check_word("BAUD after reset", wb_data_t'(`SOC_BAUD_RESET), rdata);

    for (int n = 0; n < num_records; n++) begin
      rec      = patterns[n];
      op       = rec[83:80];
      addr     = rec[79:64];
      value    = rec[63:32];
      expected = rec[31:0];
      case (op)
        OP_WRITE: begin
          bus_access(1'b1, addr, value, rdata);
          if (addr == BAUD_ADDR) begin
            bit_cycles = int'(value[15:0]);
          end
        end
        OP_READ: begin
          bus_access(1'b0, addr, '0, rdata);
          check_word($sformatf("wb_dat_o at %h", addr), expected, rdata);
        end
        OP_BUTTONS: begin
          btn_i = led_t'(value);
          repeat (4) @(negedge clk_i);
        end
        OP_TRANSMIT: begin
          transmit_byte(uart_byte_t'(addr), uart_byte_t'(value), uart_byte_t'(expected));
        end
        OP_RECEIVE: send_frame(uart_byte_t'(addr));
        OP_LED:     check_led("led_o", led_t'(expected), led_o);
        OP_FILL:    fill_ram(addr, int'(value));
        OP_VERIFY:  verify_ram(addr, int'(value));
        default: begin
          stop_with_failure($sformatf("unknown opcode %h in record %0d", op, n));
        end
      endcase
    end

    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* testbench/soc_asserts.sv */
`timescale 1ns/1ps

module soc_asserts
  (
    input logic clk_i,
    input logic anrst_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic tx_start_i,
    input logic tx_busy_i
  );

  // ack answers a live request only
  ack_needs_request: assert property (
    @(posedge clk_i) disable iff (!anrst_i)
    $rose(ack_i) |-> $past(cyc_i && stb_i)
  ) else $error("wb_ack_o rose without cyc and stb");

  ack_single_cycle: assert property (
    @(posedge clk_i) disable iff (!anrst_i)
    ack_i |=> !ack_i
  ) else $error("wb_ack_o stayed high for two cycles");

  // the register block holds a start back while a frame runs
  tx_start_when_idle: assert property (
    @(posedge clk_i) disable iff (!anrst_i)
    tx_start_i |-> !tx_busy_i
  ) else $error("tx_start pulsed while the transmitter was busy");

endmodule

bind soc_top soc_asserts u_asserts (
  .clk_i      (clk_i),
  .anrst_i    (rst_n),
  .cyc_i      (wb_cyc_i),
  .stb_i      (wb_stb_i),
  .ack_i      (wb_ack_o),
  .tx_start_i (tx_start),
  .tx_busy_i  (tx_busy)
);

/* rtl/soc_top.sv */
`timescale 1ns/1ps

module soc_top
  import soc_pkg::*;
  (
    input  logic     clk_i,
    input  logic     anrst_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    input  logic     uart_rx_i,
    output logic     uart_tx_o,
    input  led_t     btn_i,
    output led_t     led_o
  );

  logic [1:0] rst_sync;
  logic       rst_n;

  // bus fan-out
  logic       ram_stb;
  logic       reg_stb;
  wb_data_t   ram_dat;
  wb_data_t   reg_dat;
  logic       ram_ack;
  logic       reg_ack;

  // register block to UART
  baud_div_t  baud_div;
  uart_byte_t tx_data;
  logic       tx_start;
  logic       tx_busy;
  uart_byte_t rx_data;
  logic       rx_strobe;

  //////////////////////
  // reset
  //////////////////////

  // asserts at once, releases on the second edge
  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rst_n = rst_sync[1];

  //////////////////////
  // blocks
  //////////////////////

  soc_bus_decoder u_decoder (
    .clk_i     (clk_i),
    .anrst_i   (rst_n),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .adr_i     (wb_adr_i),
    .dat_o     (wb_dat_o),
    .ack_o     (wb_ack_o),
    .ram_stb_o (ram_stb),
    .reg_stb_o (reg_stb),
    .ram_dat_i (ram_dat),
    .ram_ack_i (ram_ack),
    .reg_dat_i (reg_dat),
    .reg_ack_i (reg_ack)
  );

  soc_ram u_ram (
    .clk_i   (clk_i),
    .anrst_i (rst_n),
    .cyc_i   (wb_cyc_i),
    .stb_i   (ram_stb),
    .we_i    (wb_we_i),
    .adr_i   (wb_adr_i),
    .dat_i   (wb_dat_i),
    .dat_o   (ram_dat),
    .ack_o   (ram_ack)
  );

  soc_ctrl_regs u_regs (
    .clk_i       (clk_i),
    .anrst_i     (rst_n),
    .cyc_i       (wb_cyc_i),
    .stb_i       (reg_stb),
    .we_i        (wb_we_i),
    .adr_i       (wb_adr_i),
    .dat_i       (wb_dat_i),
    .dat_o       (reg_dat),
    .ack_o       (reg_ack),
    .btn_i       (btn_i),
    .led_o       (led_o),
    .baud_div_o  (baud_div),
    .tx_data_o   (tx_data),
    .tx_start_o  (tx_start),
    .tx_busy_i   (tx_busy),
    .rx_data_i   (rx_data),
    .rx_strobe_i (rx_strobe)
  );

  soc_uart u_uart (
    .clk_i       (clk_i),
    .anrst_i     (rst_n),
    .baud_div_i  (baud_div),
    .tx_data_i   (tx_data),
    .tx_start_i  (tx_start),
    .tx_busy_o   (tx_busy),
    .uart_tx_o   (uart_tx_o),
    .uart_rx_i   (uart_rx_i),
    .rx_data_o   (rx_data),
    .rx_strobe_o (rx_strobe)
  );

endmodule

/* rtl/soc_bus_decoder.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_bus_decoder
  import soc_pkg::*;
  (
    input  logic     clk_i,
    input  logic     anrst_i,
    input  logic     cyc_i,
    input  logic     stb_i,
    input  wb_addr_t adr_i,
    output wb_data_t dat_o,
    output logic     ack_o,
    output logic     ram_stb_o,
    output logic     reg_stb_o,
    input  wb_data_t ram_dat_i,
    input  logic     ram_ack_i,
    input  wb_data_t reg_dat_i,
    input  logic     reg_ack_i
  );

  localparam wb_addr_t RAM_SPAN = wb_addr_t'(4 << `SOC_RAM_ADDR_W);
  localparam wb_addr_t REG_SPAN = wb_addr_t'(4 * `SOC_REG_WORDS);

  wb_addr_t ram_off;
  wb_addr_t reg_off;
  logic     ram_hit;
  logic     reg_hit;
  logic     miss_ack;

  // offsets wrap below the base, so one compare covers both ends
  assign ram_off = adr_i - wb_addr_t'(`SOC_RAM_BASE);
  assign reg_off = adr_i - wb_addr_t'(`SOC_REG_BASE);
  assign ram_hit = (ram_off < RAM_SPAN);
  assign reg_hit = (reg_off < REG_SPAN) & ~ram_hit;

  assign ram_stb_o = stb_i & ram_hit;
  assign reg_stb_o = stb_i & reg_hit;

  // unmapped addresses get their own ack one cycle later
  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      miss_ack <= 1'b0;
    end else begin
      miss_ack <= cyc_i & stb_i & ~ram_hit & ~reg_hit & ~miss_ack;
    end
  end

  assign dat_o = ram_hit ? ram_dat_i : (reg_hit ? reg_dat_i : '0);
  assign ack_o = ram_hit ? ram_ack_i : (reg_hit ? reg_ack_i : miss_ack);

endmodule

/* rtl/soc_ctrl_regs.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_ctrl_regs
  import soc_pkg::*;
  (
    input  logic       clk_i,
    input  logic       anrst_i,
    input  logic       cyc_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  wb_addr_t   adr_i,
    input  wb_data_t   dat_i,
    output wb_data_t   dat_o,
    output logic       ack_o,
    input  led_t       btn_i,
    output led_t       led_o,
    output baud_div_t  baud_div_o,
    output uart_byte_t tx_data_o,
    output logic       tx_start_o,
    input  logic       tx_busy_i,
    input  uart_byte_t rx_data_i,
    input  logic       rx_strobe_i
  );

  wb_addr_t   offset;
  logic [2:0] sel;
  logic       access;
  logic       wr;
  logic       rd;
  logic       tx_pend;
  logic       tx_active;
  led_t       btn_meta;
  led_t       btn_sync;
  uart_byte_t rx_byte;
  logic       rx_valid;
  logic       rx_overrun;

  assign offset = adr_i - wb_addr_t'(`SOC_REG_BASE);
  assign sel    = offset[4:2];
  assign access = cyc_i & stb_i & ~ack_o;
  assign wr     = access & we_i;
  assign rd     = access & ~we_i;

  // busy from the TXDATA write until the frame ends
  assign tx_active = tx_busy_i | tx_pend | tx_start_o;

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      ack_o      <= 1'b0;
      led_o      <= '0;
      baud_div_o <= baud_div_t'(`SOC_BAUD_RESET);
      tx_pend    <= 1'b0;
      tx_start_o <= 1'b0;
      btn_meta   <= '0;
      btn_sync   <= '0;
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end else begin
      ack_o      <= access;
      btn_meta   <= btn_i;
      btn_sync   <= btn_meta;
      // start goes out the cycle after the ack
      tx_start_o <= tx_pend;
      tx_pend    <= 1'b0;
      if (wr && sel == 3'd0) begin
        led_o <= led_t'(dat_i);
      end
      if (wr && sel == 3'd2) begin
        baud_div_o <= baud_div_t'(dat_i);
      end
      // dropped while a frame is under way
      if (wr && sel == 3'd3 && !tx_active) begin
        tx_pend <= 1'b1;
      end
      if (rd && sel == 3'd4) begin
        rx_valid   <= 1'b0;
        rx_overrun <= 1'b0;
      end
      if (rx_strobe_i) begin
        if (rx_valid && !(rd && sel == 3'd4)) begin
          rx_overrun <= 1'b1;
        end else begin
          rx_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && sel == 3'd3 && !tx_active) begin
      tx_data_o <= uart_byte_t'(dat_i);
    end
    // first byte is kept on overrun
    if (rx_strobe_i && (!rx_valid || (rd && sel == 3'd4))) begin
      rx_byte <= rx_data_i;
    end
    if (rd) begin
      case (sel)
        3'd0:    dat_o <= wb_data_t'(led_o);
        3'd1:    dat_o <= wb_data_t'(btn_sync);
        3'd2:    dat_o <= wb_data_t'(baud_div_o);
        3'd4:    dat_o <= wb_data_t'(rx_byte);
        3'd5:    dat_o <= wb_data_t'({rx_overrun, rx_valid, tx_active});
        default: dat_o <= '0;
      endcase
    end
  end

endmodule

/* rtl/soc_uart.sv */
`timescale 1ns/1ps

module soc_uart
  import soc_pkg::*;
  (
    input  logic       clk_i,
    input  logic       anrst_i,
    input  baud_div_t  baud_div_i,
    input  uart_byte_t tx_data_i,
    input  logic       tx_start_i,
    output logic       tx_busy_o,
    output logic       uart_tx_o,
    input  logic       uart_rx_i,
    output uart_byte_t rx_data_o,
    output logic       rx_strobe_o
  );

  //////////////////////
  // transmitter
  //////////////////////

  uart_tx_state_t tx_state;
  baud_div_t      tx_div;
  baud_div_t      tx_cnt;
  logic [2:0]     tx_idx;
  uart_byte_t     tx_shift;

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      tx_state <= TX_IDLE;
      tx_cnt   <= '0;
      tx_idx   <= '0;
    end else if (tx_state == TX_IDLE) begin
      if (tx_start_i) begin
        tx_state <= TX_START;
        tx_cnt   <= baud_div_i - 1'b1;
      end
    end else if (tx_cnt != '0) begin
      tx_cnt <= tx_cnt - 1'b1;
    end else begin
      // end of one bit time
      tx_cnt <= tx_div - 1'b1;
      case (tx_state)
        TX_START: begin
          tx_state <= TX_DATA;
          tx_idx   <= '0;
        end
        TX_DATA: begin
          tx_idx <= tx_idx + 1'b1;
          if (tx_idx == 3'd7) begin
            tx_state <= TX_STOP;
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  // byte and divisor are latched per frame, so BAUD changes wait for the next one
  always_ff @(posedge clk_i) begin
    if (tx_state == TX_IDLE && tx_start_i) begin
      tx_shift <= tx_data_i;
      tx_div   <= baud_div_i;
    end else if (tx_state == TX_DATA && tx_cnt == '0) begin
      tx_shift <= tx_shift >> 1;
    end
  end

  always_comb begin
    case (tx_state)
      TX_START: uart_tx_o = 1'b0;
      TX_DATA:  uart_tx_o = tx_shift[0];
      default:  uart_tx_o = 1'b1;
    endcase
  end

  assign tx_busy_o = (tx_state != TX_IDLE);

  //////////////////////
  // receiver
  //////////////////////

  uart_rx_state_t rx_state;
  logic           rx_meta;
  logic           rx_sync;
  logic           rx_prev;
  baud_div_t      rx_div;
  baud_div_t      rx_cnt;
  logic [2:0]     rx_idx;
  uart_byte_t     rx_shift;

  // two-flop synchronizer and one more flop for edge detect
  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= uart_rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      rx_state    <= RX_IDLE;
      rx_cnt      <= '0;
      rx_idx      <= '0;
      rx_strobe_o <= 1'b0;
    end else begin
      rx_strobe_o <= 1'b0;
      if (rx_state == RX_IDLE) begin
        if (rx_prev && !rx_sync) begin
          // half a bit to the start bit centre
          rx_state <= RX_START;
          rx_cnt   <= (baud_div_i >> 1) - 1'b1;
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        rx_cnt <= rx_div - 1'b1;
        case (rx_state)
          RX_START: begin
            // line high again means a glitch
            rx_state <= rx_sync ? RX_IDLE : RX_DATA;
            rx_idx   <= '0;
          end
          RX_DATA: begin
            rx_idx <= rx_idx + 1'b1;
            if (rx_idx == 3'd7) begin
              rx_state <= RX_STOP;
            end
          end
          default: begin
            rx_state    <= RX_IDLE;
            rx_strobe_o <= 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_state == RX_IDLE && rx_prev && !rx_sync) begin
      rx_div <= baud_div_i;
    end else if (rx_state == RX_DATA && rx_cnt == '0) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
  end

  // shift register is stable from the stop bit on
  assign rx_data_o = rx_shift;

endmodule

/* rtl/soc_ram.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_ram
  import soc_pkg::*;
  #(
    parameter int ADDR_W = `SOC_RAM_ADDR_W
  )
  (
    input  logic     clk_i,
    input  logic     anrst_i,
    input  logic     cyc_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  wb_addr_t adr_i,
    input  wb_data_t dat_i,
    output wb_data_t dat_o,
    output logic     ack_o
  );

  wb_data_t          mem [0:(2**ADDR_W)-1];
  logic [ADDR_W-1:0] word_addr;
  logic              access;

  // byte address to word index
  assign word_addr = adr_i[ADDR_W+1:2];

  // a new cycle, not the one just acknowledged
  assign access = cyc_i & stb_i & ~ack_o;

  always_ff @(posedge clk_i, negedge anrst_i) begin
    if (!anrst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // write and read both land on the ack edge
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        mem[word_addr] <= dat_i;
      end else begin
        dat_o <= mem[word_addr];
      end
    end
  end

endmodule

/* rtl/soc_pkg.sv */
`include "soc_config.svh"

package soc_pkg;

  // bus widths
  typedef logic [15:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // serial side
  typedef logic [7:0]  uart_byte_t;
  typedef logic [15:0] baud_div_t;

  // buttons and LEDs share one width
  typedef logic [`SOC_LED_W-1:0] led_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_t;

endpackage

/* rtl/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

//////////////////////
// address map
//////////////////////

// byte base of the data RAM
`define SOC_RAM_BASE 16'h0000
// word address width for 16 words
`define SOC_RAM_ADDR_W 4
// byte base of the control registers
`define SOC_REG_BASE 16'h1000
// LED, BTN, BAUD, TXDATA, RXDATA, STATUS
`define SOC_REG_WORDS 6

// board I/O
`define SOC_LED_W 4
// clocks per serial bit after reset
`define SOC_BAUD_RESET 16'h0364

`endif
